//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := routerOutputPort_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all run check clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "CHECKS FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+logic
logic/nocPkg.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/flitMux.sv
logic/routerOutputPort.sv
dv/routerOutputPort_checker.sv
dv/routerOutputPort_tb.sv

//--- dv/routerOutputPort_checker.sv
`timescale 1ns/1ps
`include "router_config.svh"

module routerOutputPort_checker
(
  input logic              clk,
  input logic              rst,
  input logic              localReq,
  input logic              northReq,
  input logic              eastReq,
  input logic              westReq,
  input logic              southReq,
  input nocPkg::grantState grant,
  input logic              outValid
);

  logic [`NUM_PORTS-1:0] reqs;
  logic [`NUM_PORTS:0]   grantBits;

  assign reqs      = {southReq, westReq, eastReq, northReq, localReq};
  assign grantBits = grant;

  grantLegal: assert property (@(posedge clk) disable iff (rst) $onehot(grantBits))
    else $error("grant is not one of the six one-hot states");

  validClearedByReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high in the cycle after reset");

  // new channel grant needs that channel's request one cycle earlier
  grantFollowsRequest: assert property (@(posedge clk) disable iff (rst)
    (grant != $past(grant) && grant != nocPkg::grantIdle)
      |-> |(grantBits[`NUM_PORTS:1] & $past(reqs)))
    else $error("grant moved to a channel that did not request");

endmodule

bind routerOutputPort routerOutputPort_checker protocolCheck
(
  .clk      (clk),
  .rst      (rst),
  .localReq (localReq),
  .northReq (northReq),
  .eastReq  (eastReq),
  .westReq  (westReq),
  .southReq (southReq),
  .grant    (grant),
  .outValid (outValid)
);

//--- dv/routerOutputPort_tb.sv
`timescale 1ns/1ps
`include "router_config.svh"

module routerOutputPort_tb;

  localparam int RANDOM_CYCLES   = 1500;
  // headroom for directed tests and drain
  localparam int DIRECTED_BUDGET = 1000;
  localparam int TIMEOUT_CYCLES  = 2 * (RANDOM_CYCLES + DIRECTED_BUDGET);

  logic                        clk;
  logic                        rst;
  logic [`NUM_PORTS-1:0]       req;
  logic [`FLIT_WIDTH-1:0]      flit [`NUM_PORTS];
  logic [`FLIT_KIND_WIDTH-1:0] kind [`NUM_PORTS];
  logic [`LENGTH_WIDTH-1:0]    len [`NUM_PORTS];
  nocPkg::grantState           grant;
  nocPkg::grantState           outPort;
  logic [`FLIT_WIDTH-1:0]      outFlit;
  logic                        outValid;

  // reference model state
  nocPkg::grantState        modelGrant;
  nocPkg::grantState        modelPort;
  logic                     modelValid;
  logic [`FLIT_WIDTH-1:0]   modelFlit;
  logic [`LENGTH_WIDTH-1:0] modelCount [`NUM_PORTS];
  logic [`LENGTH_WIDTH-1:0] modelLen [`NUM_PORTS];
  logic                     checking = 1'b0;
  int                       cycleCount = 0;

  routerOutputPort dut
  (
    .clk           (clk),
    .rst           (rst),
    .localReq      (req[0]),
    .localFlit     (flit[0]),
    .localFlitKind (kind[0]),
    .localLength   (len[0]),
    .northReq      (req[1]),
    .northFlit     (flit[1]),
    .northFlitKind (kind[1]),
    .northLength   (len[1]),
    .eastReq       (req[2]),
    .eastFlit      (flit[2]),
    .eastFlitKind  (kind[2]),
    .eastLength    (len[2]),
    .westReq       (req[3]),
    .westFlit      (flit[3]),
    .westFlitKind  (kind[3]),
    .westLength    (len[3]),
    .southReq      (req[4]),
    .southFlit     (flit[4]),
    .southFlitKind (kind[4]),
    .southLength   (len[4]),
    .grant         (grant),
    .outFlit       (outFlit),
    .outValid      (outValid),
    .outPort       (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic nocPkg::grantState grantFor(input int ch);
    logic [`NUM_PORTS:0] bits;
    bits = '0;
    bits[ch + 1] = 1'b1;
    return nocPkg::grantState'(bits);
  endfunction

  // -1 means idle
  function automatic int channelOf(input nocPkg::grantState g);
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      if (g == grantFor(k))
        return k;
    end
    return -1;
  endfunction

  // the current holder is never re-entered directly
  function automatic nocPkg::grantState nextGrant(input nocPkg::grantState cur,
                                                  input logic [`NUM_PORTS-1:0] reqs);
    int chan;
    int idx;
    chan = channelOf(cur);
    if (chan < 0)
    begin
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        if (reqs[k])
          return grantFor(k);
      end
      return nocPkg::grantIdle;
    end
    if (reqs[chan] && modelCount[chan] != modelLen[chan])
      return cur;
    for (int k = 1; k < `NUM_PORTS; k++)
    begin
      idx = (chan + k) % `NUM_PORTS;
      if (reqs[idx])
        return grantFor(idx);
    end
    return nocPkg::grantIdle;
  endfunction

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // outputs and inputs both steady at negedge
  always @(negedge clk)
  begin : compareModel
    nocPkg::grantState nextG;
    int                ch;
    if (checking)
    begin
      checkValue(64'(grant), 64'(modelGrant), "grant");
      checkValue(64'(outValid), 64'(modelValid), "outValid");
      checkValue(64'(outPort), 64'(modelPort), "outPort");
      if (modelValid)
        checkValue(64'(outFlit), 64'(modelFlit), "outFlit");
    end
    if (rst)
    begin
      modelGrant = nocPkg::grantIdle;
      modelPort  = nocPkg::grantIdle;
      modelValid = 1'b0;
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        modelCount[k] = '0;
        modelLen[k]   = '0;
      end
      checking = 1'b1;
    end
    else
    begin
      nextG = nextGrant(modelGrant, req);
      ch = channelOf(modelGrant);
      // output stage lags grant by one cycle
      modelValid = (ch >= 0);
      modelPort  = modelGrant;
      if (ch >= 0)
        modelFlit = flit[ch];
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        if (k == ch && nextG == modelGrant)
          modelCount[k] = modelCount[k] + 1'b1;
        else
          modelCount[k] = '0;
        if (kind[k] == nocPkg::flitHeader)
          modelLen[k] = len[k];
      end
      modelGrant = nextG;
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // fresh flits every cycle so the model tracks the data path too
  task automatic stepCycle;
    @(posedge clk);
    #1;
    for (int k = 0; k < `NUM_PORTS; k++)
      flit[k] = $urandom;
  endtask

  task automatic holdLength(input nocPkg::grantState who, input int cycles);
    int n;
    n = 0;
    checkValue(64'(grant), 64'(who), "grant at packet start");
    while (grant == who)
    begin
      n++;
      stepCycle();
    end
    checkValue(64'(n), 64'(cycles), "grant hold cycles");
  endtask

  task automatic idleAfterReset;
    repeat (4)
    begin
      checkValue(64'(grant), 64'(nocPkg::grantIdle), "grant after reset");
      checkValue(64'(outValid), 64'(0), "outValid after reset");
      stepCycle();
    end
  endtask

  task automatic loneRequester;
    req[0] = 1'b1;
    kind[0] = nocPkg::flitHeader;
    len[0] = 12'd4;
    stepCycle();
    kind[0] = nocPkg::flitBody;
    holdLength(nocPkg::grantLocal, 5);
    checkValue(64'(grant), 64'(nocPkg::grantIdle), "idle gap between packets");
    stepCycle();
    checkValue(64'(grant), 64'(nocPkg::grantLocal), "re-grant of lone requester");
    req[0] = 1'b0;
    kind[0] = nocPkg::flitNone;
    repeat (2) stepCycle();
  endtask

  task automatic fullRotation;
    int lengths [`NUM_PORTS] = '{1, 2, 3, 0, 5};
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      req[k] = 1'b1;
      kind[k] = nocPkg::flitHeader;
      len[k] = 12'(lengths[k]);
    end
    stepCycle();
    for (int k = 0; k < `NUM_PORTS; k++)
      holdLength(grantFor(k), lengths[k] + 1);
    checkValue(64'(grant), 64'(nocPkg::grantLocal), "rotation wraps to local");
    req = '0;
    for (int k = 0; k < `NUM_PORTS; k++)
      kind[k] = nocPkg::flitNone;
    repeat (2) stepCycle();
  endtask

  task automatic dropMidPacket;
    req[0] = 1'b1;
    req[2] = 1'b1;
    kind[0] = nocPkg::flitHeader;
    kind[2] = nocPkg::flitHeader;
    len[0] = 12'd6;
    len[2] = 12'd2;
    stepCycle();
    kind[0] = nocPkg::flitBody;
    kind[2] = nocPkg::flitBody;
    repeat (2)
    begin
      checkValue(64'(grant), 64'(nocPkg::grantLocal), "grant before drop");
      stepCycle();
    end
    req[0] = 1'b0;
    stepCycle();
    checkValue(64'(grant), 64'(nocPkg::grantEast), "grant after request drop");
    req = '0;
    repeat (2) stepCycle();
  endtask

  task automatic randomTraffic;
    repeat (RANDOM_CYCLES)
    begin
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        req[k] = ($urandom % 4) != 0;
        kind[k] = 3'($urandom % 4);
        len[k] = 12'($urandom % 8);
      end
      stepCycle();
    end
  endtask

  initial
  begin
    void'($urandom(32'he00b5bc4));
    rst = 1'b1;
    req = '0;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      flit[k] = '0;
      kind[k] = nocPkg::flitNone;
      len[k]  = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    idleAfterReset();
    loneRequester();
    fullRotation();
    dropMidPacket();
    randomTraffic();
    req = '0;
    repeat (3) stepCycle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- logic/flitMux.sv
`timescale 1ns/1ps
`include "router_config.svh"

module flitMux
(
  input  logic                    clk,
  input  logic                    rst,
  input  nocPkg::grantState       grant,
  input  logic [`FLIT_WIDTH-1:0]  lFlit,
  input  logic [`FLIT_WIDTH-1:0]  nFlit,
  input  logic [`FLIT_WIDTH-1:0]  eFlit,
  input  logic [`FLIT_WIDTH-1:0]  wFlit,
  input  logic [`FLIT_WIDTH-1:0]  sFlit,
  output logic [`FLIT_WIDTH-1:0]  outFlit,
  output logic                    outValid,
  output nocPkg::grantState       outPort
);

  logic [`FLIT_WIDTH-1:0] selFlit;
  logic                   selValid;

  always_comb
  begin
    selValid = 1'b1;
    case (grant)
      nocPkg::grantLocal: selFlit = lFlit;
      nocPkg::grantNorth: selFlit = nFlit;
      nocPkg::grantEast:  selFlit = eFlit;
      nocPkg::grantWest:  selFlit = wFlit;
      nocPkg::grantSouth: selFlit = sFlit;
      default:
      begin
        selFlit  = outFlit;
        selValid = 1'b0;
      end
    endcase
  end

  // data holds its last value while idle
  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= nocPkg::grantIdle;
    end
    else
    begin
      outValid <= selValid;
      outPort  <= grant;
    end
  end

endmodule

//--- logic/nocPkg.sv
`include "router_config.svh"

package nocPkg;

  // one-hot grant, bit 0 is idle and bits 1..5 follow L, N, E, W, S
  typedef enum logic [`NUM_PORTS:0]
  {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantState;

  // kind tag carried with every flit
  typedef enum logic [`FLIT_KIND_WIDTH-1:0]
  {
    flitNone   = 3'd0,
    flitHeader = 3'd1,
    flitBody   = 3'd2,
    flitTail   = 3'd3
  } flitKind;

endpackage

//--- logic/outputArbiter.sv
`timescale 1ns/1ps
`include "router_config.svh"

module outputArbiter
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        lReq,
  input  logic                        nReq,
  input  logic                        eReq,
  input  logic                        wReq,
  input  logic                        sReq,
  input  logic [`FLIT_KIND_WIDTH-1:0] lFlitKind,
  input  logic [`FLIT_KIND_WIDTH-1:0] nFlitKind,
  input  logic [`FLIT_KIND_WIDTH-1:0] eFlitKind,
  input  logic [`FLIT_KIND_WIDTH-1:0] wFlitKind,
  input  logic [`FLIT_KIND_WIDTH-1:0] sFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    lLength,
  input  logic [`LENGTH_WIDTH-1:0]    nLength,
  input  logic [`LENGTH_WIDTH-1:0]    eLength,
  input  logic [`LENGTH_WIDTH-1:0]    wLength,
  input  logic [`LENGTH_WIDTH-1:0]    sLength,
  output nocPkg::grantState           grant
);

  logic [`NUM_PORTS-1:0] reqs;
  logic [`NUM_PORTS-1:0] runTimer;
  logic [`NUM_PORTS-1:0] timesUp;
  nocPkg::grantState     nextGrant;

  // index 0 is local, 4 is south
  assign reqs = {sReq, wReq, eReq, nReq, lReq};

  // first requester in rotation order beginning at channel start
  function automatic nocPkg::grantState pickNext
  (
    input logic [`NUM_PORTS-1:0] candidates,
    input int                    start
  );
    logic [`NUM_PORTS:0] oneHot;
    int                  idx;
    oneHot = '0;
    oneHot[0] = 1'b1;
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (candidates[idx])
      begin
        oneHot = '0;
        oneHot[idx + 1] = 1'b1;
      end
    end
    return nocPkg::grantState'(oneHot);
  endfunction

  // stay while requesting and the packet is not done, else rotate on
  function automatic nocPkg::grantState holdOrRotate
  (
    input logic [`NUM_PORTS-1:0] candidates,
    input logic [`NUM_PORTS-1:0] done,
    input int                    chan
  );
    logic [`NUM_PORTS-1:0] others;
    logic [`NUM_PORTS:0]   oneHot;
    others = candidates;
    others[chan] = 1'b0;
    oneHot = '0;
    oneHot[chan + 1] = 1'b1;
    if (candidates[chan] && !done[chan])
    begin
      return nocPkg::grantState'(oneHot);
    end
    return pickNext(others, chan + 1);
  endfunction

  always_comb
  begin
    runTimer = '0;
    case (grant)
      nocPkg::grantIdle:
      begin
        nextGrant = pickNext(reqs, 0);
      end
      nocPkg::grantLocal:
      begin
        nextGrant = holdOrRotate(reqs, timesUp, 0);
        runTimer[0] = (nextGrant == nocPkg::grantLocal);
      end
      nocPkg::grantNorth:
      begin
        nextGrant = holdOrRotate(reqs, timesUp, 1);
        runTimer[1] = (nextGrant == nocPkg::grantNorth);
      end
      nocPkg::grantEast:
      begin
        nextGrant = holdOrRotate(reqs, timesUp, 2);
        runTimer[2] = (nextGrant == nocPkg::grantEast);
      end
      nocPkg::grantWest:
      begin
        nextGrant = holdOrRotate(reqs, timesUp, 3);
        runTimer[3] = (nextGrant == nocPkg::grantWest);
      end
      nocPkg::grantSouth:
      begin
        nextGrant = holdOrRotate(reqs, timesUp, 4);
        runTimer[4] = (nextGrant == nocPkg::grantSouth);
      end
      default:
      begin
        nextGrant = nocPkg::grantIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= nocPkg::grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  packetTimer lTimer
  (
    .clk        (clk),
    .rst        (rst),
    .flitKindIn (lFlitKind),
    .length     (lLength),
    .runTimer   (runTimer[0]),
    .timesUp    (timesUp[0])
  );

  packetTimer nTimer
  (
    .clk        (clk),
    .rst        (rst),
    .flitKindIn (nFlitKind),
    .length     (nLength),
    .runTimer   (runTimer[1]),
    .timesUp    (timesUp[1])
  );

  packetTimer eTimer
  (
    .clk        (clk),
    .rst        (rst),
    .flitKindIn (eFlitKind),
    .length     (eLength),
    .runTimer   (runTimer[2]),
    .timesUp    (timesUp[2])
  );

  packetTimer wTimer
  (
    .clk        (clk),
    .rst        (rst),
    .flitKindIn (wFlitKind),
    .length     (wLength),
    .runTimer   (runTimer[3]),
    .timesUp    (timesUp[3])
  );

  packetTimer sTimer
  (
    .clk        (clk),
    .rst        (rst),
    .flitKindIn (sFlitKind),
    .length     (sLength),
    .runTimer   (runTimer[4]),
    .timesUp    (timesUp[4])
  );

endmodule

//--- logic/packetTimer.sv
`timescale 1ns/1ps
`include "router_config.svh"

module packetTimer
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`FLIT_KIND_WIDTH-1:0] flitKindIn,
  input  logic [`LENGTH_WIDTH-1:0]    length,
  input  logic                        runTimer,
  output logic                        timesUp
);

  logic [`LENGTH_WIDTH-1:0] latchedLength;
  logic [`LENGTH_WIDTH-1:0] count;

  // header flit carries the packet length
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      latchedLength <= '0;
    end
    else if (flitKindIn == nocPkg::flitHeader)
    begin
      latchedLength <= length;
    end
  end

  // counts only while the arbiter stays on this channel
  always_ff @(posedge clk)
  begin
    if (rst || !runTimer)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign timesUp = (count == latchedLength);

endmodule

//--- logic/routerOutputPort.sv
`timescale 1ns/1ps
`include "router_config.svh"

module routerOutputPort
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        localReq,
  input  logic [`FLIT_WIDTH-1:0]      localFlit,
  input  logic [`FLIT_KIND_WIDTH-1:0] localFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    localLength,
  input  logic                        northReq,
  input  logic [`FLIT_WIDTH-1:0]      northFlit,
  input  logic [`FLIT_KIND_WIDTH-1:0] northFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    northLength,
  input  logic                        eastReq,
  input  logic [`FLIT_WIDTH-1:0]      eastFlit,
  input  logic [`FLIT_KIND_WIDTH-1:0] eastFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    eastLength,
  input  logic                        westReq,
  input  logic [`FLIT_WIDTH-1:0]      westFlit,
  input  logic [`FLIT_KIND_WIDTH-1:0] westFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    westLength,
  input  logic                        southReq,
  input  logic [`FLIT_WIDTH-1:0]      southFlit,
  input  logic [`FLIT_KIND_WIDTH-1:0] southFlitKind,
  input  logic [`LENGTH_WIDTH-1:0]    southLength,
  output nocPkg::grantState           grant,
  output logic [`FLIT_WIDTH-1:0]      outFlit,
  output logic                        outValid,
  output nocPkg::grantState           outPort
);

  // grant leads the forwarded flit by one cycle
  outputArbiter arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .lReq      (localReq),
    .nReq      (northReq),
    .eReq      (eastReq),
    .wReq      (westReq),
    .sReq      (southReq),
    .lFlitKind (localFlitKind),
    .nFlitKind (northFlitKind),
    .eFlitKind (eastFlitKind),
    .wFlitKind (westFlitKind),
    .sFlitKind (southFlitKind),
    .lLength   (localLength),
    .nLength   (northLength),
    .eLength   (eastLength),
    .wLength   (westLength),
    .sLength   (southLength),
    .grant     (grant)
  );

  flitMux mux
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (localFlit),
    .nFlit    (northFlit),
    .eFlit    (eastFlit),
    .wFlit    (westFlit),
    .sFlit    (southFlit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

//--- logic/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// flit payload
`define FLIT_WIDTH 32

// packet length and timer count
`define LENGTH_WIDTH 12

`define FLIT_KIND_WIDTH 3

// input channels L, N, E, W, S
`define NUM_PORTS 5
`endif
